//--- build.f
src/memPkg.sv
src/memHandshake.sv
src/memLaneSplitter.sv
src/byteBank.sv
src/memLaneMerger.sv
src/ramByteLaned.sv
dv/ramTb.sv

//--- dv/ramTb.sv
`timescale 1ns/1ps
`default_nettype none

module ramTb;

	localparam int initWords = memPkg::memBytes / memPkg::laneCount;	// 64 words to fill.
	localparam int randomOps = 2000;					// Random requests after the fill.
	localparam int cycleLimit = (initWords + randomOps) * 8 + 100;	// Worst case plus margin.
	localparam int expLatency = 2;					// Edges from E0 to moc high.

	logic clk;
	logic reset;
	logic mov;
	logic readWrite;
	logic [2:0] ms;
	logic [31:0] address;
	memPkg::dataWord dataIn;
	logic moc;
	memPkg::dataWord dataOut;

	logic [7:0] model [memPkg::memBytes];				// Reference byte image.
	memPkg::dataWord lastRead;						// Predicted dataOut.
	int cycleCount;

	ramByteLaned dut_i
	(
		.clk(clk),
		.reset(reset),
		.mov(mov),
		.readWrite(readWrite),
		.ms(ms),
		.address(address),
		.dataIn(dataIn),
		.moc(moc),
		.dataOut(dataOut)
	);

	always #5 clk = ~clk;							// 10 ns period.

	// Global run limit.
	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout: the run did not finish within %0d cycles.", cycleLimit);
			$display("TB FAILED");
			$fatal(1, "Cycle limit reached.");
		end
	end

	task automatic checkData(input memPkg::dataWord got, input memPkg::dataWord exp,
		input string what);
		if (got !== exp)
		begin
			$display("ERR @%0t: %s got %08h expected %08h", $time, what, got, exp);
			$display("TB FAILED");
			$fatal(1, "Data mismatch.");
		end
	endtask

	task automatic checkLatency(input int got);
		if (got != expLatency)
		begin
			$display("ERR @%0t: moc latency %0d cycles expected %0d", $time, got, expLatency);
			$display("TB FAILED");
			$fatal(1, "Latency mismatch.");
		end
	endtask

	task automatic checkMoc(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("ERR @%0t: %s got moc %b expected %b", $time, what, got, exp);
			$display("TB FAILED");
			$fatal(1, "Handshake mismatch.");
		end
	endtask

	// Big-endian byte memory with forced alignment.
	task automatic applyModel(input logic rd, input logic [2:0] code, input logic [31:0] addr,
		input memPkg::dataWord data);
		logic [7:0] a;
		logic [7:0] b;
		logic [15:0] h;
		a = addr[7:0];								// Upper bits alias.
		case (code[1:0])
			memPkg::sizeByte:
				if (rd)
				begin
					b = model[a];
					lastRead = {{24{code[2] & b[7]}}, b};
				end
				else
					model[a] = data[7:0];
			memPkg::sizeHalf:
			begin
				a[0] = 1'b0;						// Even address.
				if (rd)
				begin
					h = {model[a], model[a + 8'd1]};
					lastRead = {{16{code[2] & h[15]}}, h};
				end
				else
				begin
					model[a] = data[15:8];
					model[a + 8'd1] = data[7:0];
				end
			end
			memPkg::sizeWord:
			begin
				a[1:0] = 2'b00;						// Word boundary.
				if (rd)
					lastRead = {model[a], model[a + 8'd1], model[a + 8'd2], model[a + 8'd3]};
				else
				begin
					model[a] = data[31:24];
					model[a + 8'd1] = data[23:16];
					model[a + 8'd2] = data[15:8];
					model[a + 8'd3] = data[7:0];
				end
			end
			default:
				;									// sizeNone keeps memory and dataOut.
		endcase
	endtask

	// One full four-phase handshake from posedge plus 1 ns.
	task automatic runRequest(input logic rd, input logic [2:0] code, input logic [31:0] addr,
		input memPkg::dataWord data, input int hold);
		int edges;
		checkMoc(moc, 1'b0, "moc before request");
		mov = 1'b1;
		readWrite = rd;
		ms = code;
		address = addr;
		dataIn = data;
		applyModel(rd, code, addr, data);
		edges = 0;
		do
		begin
			@(posedge clk);
			#1;
			edges++;
		end
		while (!moc);
		checkLatency(edges - 1);					// First edge is E0.
		checkData(dataOut, lastRead, "dataOut at moc");
		repeat (hold)
		begin
			@(posedge clk);
			#1;
			checkMoc(moc, 1'b1, "moc during hold");
		end
		mov = 1'b0;
		@(posedge clk);
		#1;
		checkMoc(moc, 1'b0, "moc after mov low");
		checkData(dataOut, lastRead, "dataOut after release");
	endtask

	initial
	begin
		logic [31:0] rnd;
		logic [31:0] upper;
		clk = 1'b0;
		reset = 1'b1;
		mov = 1'b0;
		readWrite = 1'b0;
		ms = 3'b000;
		address = '0;
		dataIn = '0;
		cycleCount = 0;
		lastRead = '0;								// dataOut resets to zero.
		rnd = $urandom(12580);						// Seeds the generator once.
		for (int i = 0; i < memPkg::memBytes; i++)
			model[i] = 8'h00;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		checkMoc(moc, 1'b0, "moc after reset");
		checkData(dataOut, '0, "dataOut after reset");
		// Fill every word so later reads see known bytes.
		for (int w = 0; w < initWords; w++)
		begin
			upper = $urandom;
			runRequest(1'b0, 3'b010, {upper[23:0], 8'(w * 4)}, $urandom, 0);
		end
		for (int n = 0; n < randomOps; n++)
		begin
			rnd = $urandom;
			runRequest(rnd[0], rnd[3:1], $urandom, $urandom, int'(rnd[5:4]));
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the memory testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

buildLog=build.log
simLog=sim.log

rm -rf obj_dir

verilator --binary --timing --timescale 1ns/1ps -f build.f --top-module ramTb \
	-Mdir obj_dir -o ramSim > "$buildLog" 2>&1 \
	|| { echo "Verilator build failed, see $buildLog"; exit 1; }

./obj_dir/ramSim > "$simLog" 2>&1 || echo "Simulator exited with an error status"

cat "$simLog"

grep -q "TB FAILED" "$simLog" && { echo "Simulation failed, see $simLog"; exit 1; }
grep -q "TB PASSED" "$simLog" || { echo "No pass result in $simLog"; exit 1; }

echo "Simulation passed"
exit 0

//--- src/byteBank.sv
`timescale 1ns/1ps
`default_nettype none

module byteBank
(
	input wire logic clk,
	input wire memPkg::laneCmd cmd,				// Command for this lane.
	output logic [7:0] rdByte						// Registered read byte.
);

	logic [7:0] mem [memPkg::bankDepth];			// Storage, not cleared by reset.

	always_ff @(posedge clk)
	begin
		if (cmd.enable)
		begin
			if (cmd.write)
				mem[cmd.bankAddr] <= cmd.wrByte;	// Store byte.
			else
				rdByte <= mem[cmd.bankAddr];		// Register read byte.
		end
	end

endmodule

`default_nettype wire

//--- src/memHandshake.sv
`timescale 1ns/1ps
`default_nettype none

module memHandshake
(
	input wire logic clk,
	input wire logic reset,
	input wire logic mov,							// Request valid from processor.
	input wire logic readWrite,						// One means read.
	input wire logic [2:0] ms,						// Sign flag and access size.
	input wire logic [31:0] address,				// Full processor address.
	input wire memPkg::dataWord dataIn,				// Write data.
	output memPkg::memReq req,						// Latched request.
	output logic issue,								// Banks act on this cycle's edge.
	output logic collect,							// Merger captures on this cycle's edge.
	output logic moc								// Memory operation complete.
);

	typedef enum logic [1:0]
	{
		stIdle,										// Waiting for mov.
		stAccess,									// Lane commands go to the banks.
		stCollect,									// Bank bytes go to the merger.
		stDone										// moc high until mov falls.
	} hsState;

	hsState state;
	logic accept;

	assign accept = (state == stIdle) && mov;		// New request seen in idle.

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= stIdle;
		end
		else
		begin
			case (state)
				stIdle:
					if (mov)
						state <= stAccess;			// Edge E0.
				stAccess:
					state <= stCollect;				// Edge E1, banks act.
				stCollect:
					state <= stDone;				// Edge E2, dataOut registered.
				stDone:
					if (!mov)
						state <= stIdle;			// Processor released, drop moc.
				default:
					state <= stIdle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			req.readWrite <= readWrite;
			req.signedLoad <= ms[2];				// Sign flag.
			req.size <= memPkg::accessSize'(ms[1:0]);
			req.address <= address[7:0];			// Upper bits alias.
			req.dataIn <= dataIn;
		end
	end

	assign issue = (state == stAccess);			// One cycle after E0.
	assign collect = (state == stCollect);			// One cycle after E1.
	assign moc = (state == stDone);				// Two cycles after E0.

endmodule

`default_nettype wire

//--- src/memLaneMerger.sv
`timescale 1ns/1ps
`default_nettype none

module memLaneMerger
(
	input wire logic clk,
	input wire logic reset,
	input wire memPkg::memReq req,					// Latched request.
	input wire logic collect,						// Capture strobe.
	input wire logic [memPkg::laneCount-1:0][7:0] rdBytes,	// Bytes from the banks.
	output memPkg::dataWord dataOut				// Read result to processor.
);

	memPkg::dataWord merged;
	logic [7:0] byteSel;
	logic [15:0] halfSel;
	logic capture;

	// Pick lanes by size and offset, big-endian.
	always_comb
	begin
		byteSel = rdBytes[req.address[1:0]];		// Addressed byte.
		halfSel = {rdBytes[{req.address[1], 1'b0}], rdBytes[{req.address[1], 1'b1}]};
		case (req.size)
			memPkg::sizeByte:
				merged = {{24{req.signedLoad & byteSel[7]}}, byteSel};
			memPkg::sizeHalf:
				merged = {{16{req.signedLoad & halfSel[15]}}, halfSel};
			memPkg::sizeWord:
			begin
				merged = '0;
				for (int lane = 0; lane < memPkg::laneCount; lane++)
					merged[8*(memPkg::laneCount-1-lane) +: 8] = rdBytes[lane];	// Lane 0 is MSB.
			end
			default:
				merged = dataOut;					// Hold previous result.
		endcase
	end

	// Only valid reads update the output.
	assign capture = collect && req.readWrite && (req.size != memPkg::sizeNone);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			dataOut <= '0;
		end
		else if (capture)
		begin
			dataOut <= merged;						// Edge E2.
		end
	end

endmodule

`default_nettype wire

//--- src/memLaneSplitter.sv
`timescale 1ns/1ps
`default_nettype none

module memLaneSplitter
(
	input wire memPkg::memReq req,					// Latched request.
	input wire logic issue,							// Access cycle strobe.
	output memPkg::laneCmd [memPkg::laneCount-1:0] laneCmds	// One command per bank.
);

	logic [7:0] alignedAddr;
	logic [1:0] offset;

	// Force the address onto its natural boundary.
	always_comb
	begin
		case (req.size)
			memPkg::sizeHalf:
				alignedAddr = {req.address[7:1], 1'b0};	// Even only.
			memPkg::sizeWord:
				alignedAddr = {req.address[7:2], 2'b00};	// Multiple of four.
			default:
				alignedAddr = req.address;			// Bytes need no alignment.
		endcase
	end

	assign offset = alignedAddr[1:0];				// First lane touched.

	always_comb
	begin
		laneCmds = '0;
		for (int lane = 0; lane < memPkg::laneCount; lane++)
		begin
			laneCmds[lane].write = ~req.readWrite;	// Same direction on every lane.
			laneCmds[lane].bankAddr = alignedAddr[7:2];	// Row shared by all lanes.
			case (req.size)
				memPkg::sizeByte:
				begin
					laneCmds[lane].enable = issue && (lane[1:0] == offset);
					laneCmds[lane].wrByte = req.dataIn[7:0];	// Low byte of bus.
				end
				memPkg::sizeHalf:
				begin
					laneCmds[lane].enable = issue && (lane[1] == offset[1]);
					// Upper byte on the lower lane.
					laneCmds[lane].wrByte = lane[0] ? req.dataIn[7:0] : req.dataIn[15:8];
				end
				memPkg::sizeWord:
				begin
					laneCmds[lane].enable = issue;	// All four lanes.
					laneCmds[lane].wrByte = req.dataIn[8*(memPkg::laneCount-1-lane) +: 8];
				end
				default:
					laneCmds[lane].enable = 1'b0;	// sizeNone touches no bank.
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/memPkg.sv
`default_nettype none

package memPkg;

	localparam int memBytes = 256;					// Total bytes in the memory.
	localparam int laneCount = 4;					// Byte lanes per word.
	localparam int bankDepth = memBytes / laneCount;	// Bytes per bank, 64.
	localparam int bankAddrWidth = 6;				// Address width inside one bank.

	typedef logic [31:0] dataWord;					// Processor data bus.

	// Access size, taken from ms bits 1..0.
	typedef enum logic [1:0]
	{
		sizeByte = 2'b00,							// One byte.
		sizeHalf = 2'b01,							// Two bytes, even address.
		sizeWord = 2'b10,							// Four bytes, address multiple of four.
		sizeNone = 2'b11							// No access, handshake only.
	} accessSize;

	// Request latched at the start of a handshake.
	typedef struct packed
	{
		logic readWrite;							// One means read.
		logic signedLoad;							// Sign extend on read, ms bit 2.
		accessSize size;							// Access width.
		logic [$clog2(memBytes)-1:0] address;		// Byte address, upper bits dropped.
		dataWord dataIn;							// Write data.
	} memReq;

	// Command to one byte bank.
	typedef struct packed
	{
		logic enable;								// Bank takes part in this access.
		logic write;								// Store wrByte when set, else read.
		logic [bankAddrWidth-1:0] bankAddr;			// Row inside the bank.
		logic [7:0] wrByte;							// Byte to store.
	} laneCmd;

endpackage

`default_nettype wire

//--- src/ramByteLaned.sv
`timescale 1ns/1ps
`default_nettype none

module ramByteLaned
(
	input wire logic clk,
	input wire logic reset,
	input wire logic mov,							// Processor request.
	input wire logic readWrite,						// One means read.
	input wire logic [2:0] ms,						// Sign flag and size code.
	input wire logic [31:0] address,				// Byte address.
	input wire memPkg::dataWord dataIn,			// Write data.
	output logic moc,								// Operation complete.
	output memPkg::dataWord dataOut				// Read data.
);

	memPkg::memReq req;
	logic issue;
	logic collect;
	memPkg::laneCmd [memPkg::laneCount-1:0] laneCmds;
	logic [memPkg::laneCount-1:0][7:0] rdBytes;

	memHandshake handshake_i
	(
		.clk(clk),
		.reset(reset),
		.mov(mov),
		.readWrite(readWrite),
		.ms(ms),
		.address(address),
		.dataIn(dataIn),
		.req(req),
		.issue(issue),
		.collect(collect),
		.moc(moc)
	);

	memLaneSplitter splitter_i
	(
		.req(req),
		.issue(issue),
		.laneCmds(laneCmds)
	);

	// Banks interleaved by address bits 1..0.
	for (genvar lane = 0; lane < memPkg::laneCount; lane++)
	begin : bankGen
		byteBank bank_i
		(
			.clk(clk),
			.cmd(laneCmds[lane]),
			.rdByte(rdBytes[lane])
		);
	end

	memLaneMerger merger_i
	(
		.clk(clk),
		.reset(reset),
		.req(req),
		.collect(collect),
		.rdBytes(rdBytes),
		.dataOut(dataOut)
	);

endmodule

`default_nettype wire
